// ==== verilog/cdePkg.sv ====
`default_nettype none

package cdePkg;

    //////////////////////////////////////////////////////////////
    // Data path
    //////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH       = 8;
    localparam int DIGIT_WIDTH      = 4;
    localparam int FIFO_DEPTH       = 8;
    localparam int FIFO_ADDR_WIDTH  = 3;
    localparam int FIFO_COUNT_WIDTH = FIFO_ADDR_WIDTH + 1;
    localparam int CURSOR_WIDTH     = 2;

    // Button order on the debounced vectors
    localparam int BTN_COUNT = 5;
    localparam int BTN_C     = 0;
    localparam int BTN_R     = 1;
    localparam int BTN_L     = 2;
    localparam int BTN_D     = 3;
    localparam int BTN_U     = 4;

    localparam int DEBOUNCE_CYCLES    = 20;
    localparam int DEBOUNCE_CNT_WIDTH = $clog2(DEBOUNCE_CYCLES);

    // 9600 baud from a 100 MHz clock, start + 8 data + stop
    localparam int CLKS_PER_BIT   = 10417;
    localparam int BAUD_CNT_WIDTH = $clog2(CLKS_PER_BIT);
    localparam int FRAME_BITS     = DATA_WIDTH + 2;
    localparam int BIT_CNT_WIDTH  = $clog2(FRAME_BITS);

    // Sequencer states
    localparam logic [1:0] SEQ_IDLE     = 2'd0;
    localparam logic [1:0] SEQ_WAIT_TX  = 2'd1;
    localparam logic [1:0] SEQ_START_TX = 2'd2;
    localparam logic [1:0] SEQ_WAIT_REL = 2'd3;

    // One FIFO word, filled as two digits and sent as a byte
    typedef union packed {
        struct packed {
            logic [DIGIT_WIDTH-1:0] hiDigit;
            logic [DIGIT_WIDTH-1:0] loDigit;
        } asDigits;
        struct packed {
            logic [DATA_WIDTH-1:0] dataByte;
        } asByte;
    } fifoWordT;

endpackage

`default_nettype wire

// ==== verilog/cdeFifoIf.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cdeFifoIf import cdePkg::*; ();

    // Strobes and data from the user side
    logic     push;
    fifoWordT pushWord;
    logic     pop;

    // Status from the storage side, head word shows ahead
    fifoWordT headWord;
    logic     empty;
    logic     full;

    modport store (
        input  push,
        input  pushWord,
        input  pop,
        output headWord,
        output empty,
        output full
    );

    modport user (
        output push,
        output pushWord,
        output pop,
        input  headWord,
        input  empty,
        input  full
    );

endinterface

`default_nettype wire

// ==== verilog/buttonDebounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module buttonDebounce import cdePkg::*; (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic [BTN_COUNT-1:0] btn,
    output logic [BTN_COUNT-1:0] held,
    output logic [BTN_COUNT-1:0] pressed
);

    logic [BTN_COUNT-1:0]          btnMeta;
    logic [BTN_COUNT-1:0]          btnSync;
    logic [DEBOUNCE_CNT_WIDTH-1:0] stableCnt [BTN_COUNT];

    // Buttons are asynchronous to clk
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            btnMeta <= '0;
            btnSync <= '0;
        end else begin
            btnMeta <= btn;
            btnSync <= btnMeta;
        end
    end

    // Count cycles the level differs from the accepted one
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            held    <= '0;
            pressed <= '0;
            for (int i = 0; i < BTN_COUNT; i++) begin
                stableCnt[i] <= '0;
            end
        end else begin
            for (int i = 0; i < BTN_COUNT; i++) begin
                pressed[i] <= 1'b0;
                if (btnSync[i] == held[i]) begin
                    stableCnt[i] <= '0;
                end else if (stableCnt[i] == DEBOUNCE_CNT_WIDTH'(DEBOUNCE_CYCLES - 1)) begin
                    stableCnt[i] <= '0;
                    held[i]      <= btnSync[i];
                    // Pulse only on an accepted press
                    pressed[i]   <= btnSync[i];
                end else begin
                    stableCnt[i] <= stableCnt[i] + DEBOUNCE_CNT_WIDTH'(1);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/panelControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module panelControl import cdePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [1:0]              sw,
    input  logic [BTN_COUNT-1:0]    pressed,
    output logic [CURSOR_WIDTH-1:0] cursor,
    output fifoWordT                digitWord,
    output logic [1:0]              mode,
    output logic [4:0]              modeLed
);

    logic sideB;
    logic loSelected;
    logic rdA;
    logic rdB;
    logic wrA;
    logic wrB;
    logic wrU;

    // Positions 2 and 3 belong to FIFO B
    assign sideB      = cursor[1];
    assign loSelected = !cursor[0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            cursor <= '0;
        end else if (pressed[BTN_L]) begin
            cursor <= cursor + CURSOR_WIDTH'(1);
        end else if (pressed[BTN_R]) begin
            cursor <= cursor - CURSOR_WIDTH'(1);
        end
    end

    // Digits wrap modulo 16
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            digitWord <= '0;
        end else if (pressed[BTN_U]) begin
            if (loSelected) begin
                digitWord.asDigits.loDigit <= digitWord.asDigits.loDigit + DIGIT_WIDTH'(1);
            end else begin
                digitWord.asDigits.hiDigit <= digitWord.asDigits.hiDigit + DIGIT_WIDTH'(1);
            end
        end else if (pressed[BTN_D]) begin
            if (loSelected) begin
                digitWord.asDigits.loDigit <= digitWord.asDigits.loDigit - DIGIT_WIDTH'(1);
            end else begin
                digitWord.asDigits.hiDigit <= digitWord.asDigits.hiDigit - DIGIT_WIDTH'(1);
            end
        end
    end

    // Mode LEDs straight from the switches and cursor side
    always_comb begin
        rdA = 1'b0;
        rdB = 1'b0;
        wrA = 1'b0;
        wrB = 1'b0;
        wrU = 1'b0;
        case (sw)
            2'b00: begin
                wrU = 1'b1;
                rdA = !sideB;
                rdB = sideB;
            end
            2'b01: begin
                wrA = 1'b1;
                rdB = sideB;
            end
            2'b10: begin
                wrB = 1'b1;
                rdA = !sideB;
            end
            default: begin
                wrA = !sideB;
                wrB = sideB;
            end
        endcase
    end

    assign mode    = sw;
    assign modeLed = {wrU, wrB, wrA, rdB, rdA};

endmodule

`default_nettype wire

// ==== verilog/syncFifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module syncFifo import cdePkg::*; (
    input logic     clk,
    input logic     arstN,
    cdeFifoIf.store port
);

    fifoWordT                    mem [FIFO_DEPTH];
    logic [FIFO_ADDR_WIDTH-1:0]  wrPtr;
    logic [FIFO_ADDR_WIDTH-1:0]  rdPtr;
    logic [FIFO_COUNT_WIDTH-1:0] count;

    always_ff @(posedge clk) begin
        if (port.push) begin
            mem[wrPtr] <= port.pushWord;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (port.push) begin
                wrPtr <= wrPtr + FIFO_ADDR_WIDTH'(1);
            end
            if (port.pop) begin
                rdPtr <= rdPtr + FIFO_ADDR_WIDTH'(1);
            end
            case ({port.push, port.pop})
                2'b10:   count <= count + FIFO_COUNT_WIDTH'(1);
                2'b01:   count <= count - FIFO_COUNT_WIDTH'(1);
                default: count <= count;
            endcase
        end
    end

    // Show-ahead read
    assign port.headWord = mem[rdPtr];
    assign port.empty    = (count == '0);
    assign port.full     = (count == FIFO_COUNT_WIDTH'(FIFO_DEPTH));

endmodule

`default_nettype wire

// ==== verilog/transferSequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module transferSequencer import cdePkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    pressed,
    input  logic                    held,
    input  logic [1:0]              sw,
    input  logic [CURSOR_WIDTH-1:0] cursor,
    input  fifoWordT                digitWord,
    cdeFifoIf.user                  fifoA,
    cdeFifoIf.user                  fifoB,
    input  logic                    txBusy,
    output logic                    txStart,
    output logic [DATA_WIDTH-1:0]   txByte
);

    logic [1:0] state;
    logic       sideB;
    logic       sendFromB;
    fifoWordT   sendWord;
    logic       pushA;
    logic       pushB;
    logic       moveAB;
    logic       moveBA;
    logic       sendA;
    logic       sendB;

    //////////////////////////////////////////////////////////////
    // Action decode and gating
    //////////////////////////////////////////////////////////////

    assign sideB = cursor[1];

    always_comb begin
        pushA  = 1'b0;
        pushB  = 1'b0;
        moveAB = 1'b0;
        moveBA = 1'b0;
        sendA  = 1'b0;
        sendB  = 1'b0;
        case (sw)
            2'b00: begin
                sendA = !sideB && !fifoA.empty;
                sendB = sideB && !fifoB.empty;
            end
            2'b01: begin
                pushA  = !sideB && !fifoA.full;
                moveBA = sideB && !fifoB.empty && !fifoA.full;
            end
            2'b10: begin
                moveAB = !sideB && !fifoA.empty && !fifoB.full;
                pushB  = sideB && !fifoB.full;
            end
            default: begin
                pushA = !sideB && !fifoA.full;
                pushB = sideB && !fifoB.full;
            end
        endcase
    end

    assign sendWord = sendFromB ? fifoB.headWord : fifoA.headWord;

    //////////////////////////////////////////////////////////////
    // Sequencer FSM
    //////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= SEQ_IDLE;
            sendFromB  <= 1'b0;
            fifoA.push <= 1'b0;
            fifoA.pop  <= 1'b0;
            fifoB.push <= 1'b0;
            fifoB.pop  <= 1'b0;
            txStart    <= 1'b0;
        end else begin
            // Strobes last one cycle
            fifoA.push <= 1'b0;
            fifoA.pop  <= 1'b0;
            fifoB.push <= 1'b0;
            fifoB.pop  <= 1'b0;
            txStart    <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (pressed) begin
                        fifoA.push <= pushA || moveBA;
                        fifoA.pop  <= moveAB;
                        fifoB.push <= pushB || moveAB;
                        fifoB.pop  <= moveBA;
                        if (sendA || sendB) begin
                            sendFromB <= sendB;
                            state     <= SEQ_WAIT_TX;
                        end else begin
                            // Dropped actions also wait for release
                            state <= SEQ_WAIT_REL;
                        end
                    end
                end
                SEQ_WAIT_TX: begin
                    if (!txBusy) begin
                        txStart   <= 1'b1;
                        fifoA.pop <= !sendFromB;
                        fifoB.pop <= sendFromB;
                        state     <= SEQ_START_TX;
                    end
                end
                SEQ_START_TX: begin
                    state <= SEQ_WAIT_REL;
                end
                default: begin
                    if (!held) begin
                        state <= SEQ_IDLE;
                    end
                end
            endcase
        end
    end

    // Payload follows the decode, qualified by the strobes
    always_ff @(posedge clk) begin
        fifoA.pushWord <= moveBA ? fifoB.headWord : digitWord;
        fifoB.pushWord <= moveAB ? fifoA.headWord : digitWord;
        if (state == SEQ_WAIT_TX) begin
            txByte <= sendWord.asByte.dataByte;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/uartTx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uartTx import cdePkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  txStart,
    input  logic [DATA_WIDTH-1:0] txByte,
    output logic                  txBusy,
    output logic                  tx
);

    logic [FRAME_BITS-1:0]     shiftReg;
    logic [BIT_CNT_WIDTH-1:0]  bitCnt;
    logic [BAUD_CNT_WIDTH-1:0] baudCnt;
    logic                      bitDone;

    assign bitDone = (baudCnt == BAUD_CNT_WIDTH'(CLKS_PER_BIT - 1));

    // Line idles high, LSB of the frame goes out first
    assign tx = shiftReg[0];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shiftReg <= '1;
            bitCnt   <= '0;
            baudCnt  <= '0;
            txBusy   <= 1'b0;
        end else if (!txBusy) begin
            if (txStart) begin
                // Stop bit, data, start bit
                shiftReg <= {1'b1, txByte, 1'b0};
                bitCnt   <= '0;
                baudCnt  <= '0;
                txBusy   <= 1'b1;
            end
        end else if (bitDone) begin
            baudCnt  <= '0;
            shiftReg <= {1'b1, shiftReg[FRAME_BITS-1:1]};
            if (bitCnt == BIT_CNT_WIDTH'(FRAME_BITS - 1)) begin
                // End of stop bit
                txBusy <= 1'b0;
            end else begin
                bitCnt <= bitCnt + BIT_CNT_WIDTH'(1);
            end
        end else begin
            baudCnt <= baudCnt + BAUD_CNT_WIDTH'(1);
        end
    end

endmodule

`default_nettype wire

// ==== verilog/cdeBoard.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdeBoard import cdePkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  logic [1:0] sw,
    input  logic       btnU,
    input  logic       btnD,
    input  logic       btnL,
    input  logic       btnR,
    input  logic       btnC,
    output logic [9:0] led,
    output logic       tx
);

    logic [BTN_COUNT-1:0]    held;
    logic [BTN_COUNT-1:0]    pressed;
    logic [CURSOR_WIDTH-1:0] cursor;
    fifoWordT                digitWord;
    logic [1:0]              mode;
    logic [4:0]              modeLed;
    logic                    txStart;
    logic [DATA_WIDTH-1:0]   txByte;
    logic                    txBusy;

    cdeFifoIf fifoA ();
    cdeFifoIf fifoB ();

    //////////////////////////////////////////////////////////////
    // Buttons and panel
    //////////////////////////////////////////////////////////////

    buttonDebounce buttonDebounce_inst (
        .clk     (clk),
        .arstN   (arstN),
        .btn     ({btnU, btnD, btnL, btnR, btnC}),
        .held    (held),
        .pressed (pressed)
    );

    panelControl panelControl_inst (
        .clk       (clk),
        .arstN     (arstN),
        .sw        (sw),
        .pressed   (pressed),
        .cursor    (cursor),
        .digitWord (digitWord),
        .mode      (mode),
        .modeLed   (modeLed)
    );

    //////////////////////////////////////////////////////////////
    // FIFOs, sequencer and UART
    //////////////////////////////////////////////////////////////

    syncFifo syncFifoA_inst (.clk(clk), .arstN(arstN), .port(fifoA.store));
    syncFifo syncFifoB_inst (.clk(clk), .arstN(arstN), .port(fifoB.store));

    transferSequencer transferSequencer_inst (
        .clk       (clk),
        .arstN     (arstN),
        .pressed   (pressed[BTN_C]),
        .held      (held[BTN_C]),
        .sw        (mode),
        .cursor    (cursor),
        .digitWord (digitWord),
        .fifoA     (fifoA.user),
        .fifoB     (fifoB.user),
        .txBusy    (txBusy),
        .txStart   (txStart),
        .txByte    (txByte)
    );

    uartTx uartTx_inst (
        .clk     (clk),
        .arstN   (arstN),
        .txStart (txStart),
        .txByte  (txByte),
        .txBusy  (txBusy),
        .tx      (tx)
    );

    // Status LEDs
    assign led[4:0] = modeLed;
    assign led[5]   = txBusy;
    assign led[6]   = fifoA.empty;
    assign led[7]   = fifoA.full;
    assign led[8]   = fifoB.empty;
    assign led[9]   = fifoB.full;

endmodule

`default_nettype wire

// ==== verif/cdeBoard_chk.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdeBoard_chk (
    input logic       clk,
    input logic       arstN,
    input logic [9:0] led,
    input logic       tx
);

    // Line idles high whenever no frame is in flight
    txIdleHigh: assert property (
        @(posedge clk) disable iff (!arstN) !led[5] |-> tx
    ) else $error("tx is low while the transmitter is idle");

    fifoAStatus: assert property (
        @(posedge clk) disable iff (!arstN) !(led[6] && led[7])
    ) else $error("FIFO A shows empty and full together");

    fifoBStatus: assert property (
        @(posedge clk) disable iff (!arstN) !(led[8] && led[9])
    ) else $error("FIFO B shows empty and full together");

    // wrU only in the send mode
    uartModeExclusive: assert property (
        @(posedge clk) disable iff (!arstN) !(led[4] && (led[2] || led[3]))
    ) else $error("wrU lit together with wrA or wrB");

endmodule

`default_nettype wire

// ==== verif/cdeBoardTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cdeBoardTb import cdePkg::*; ();

    logic                 clk;
    logic                 arstN;
    logic [1:0]           sw;
    logic [BTN_COUNT-1:0] btn;
    wire  [9:0]           led;
    wire                  tx;

    // Reference model of the panel and both FIFOs
    logic [1:0]  cursorModel;
    logic [3:0]  hiModel;
    logic [3:0]  loModel;
    logic [7:0]  queueA [$];
    logic [7:0]  queueB [$];
    logic [7:0]  expBytes [$];
    logic [31:0] lfsrState;
    int          valueErrors;
    int          otherErrors;
    int          rxRead;

    // UART receiver model
    logic        rxActive = 1'b0;
    logic [7:0]  rxShift = 8'h00;
    int          rxCnt = 0;
    int          rxErrors = 0;
    logic [7:0]  rxBytes [$];

    cdeBoard cdeBoard_inst (
        .clk   (clk),
        .arstN (arstN),
        .sw    (sw),
        .btnU  (btn[BTN_U]),
        .btnD  (btn[BTN_D]),
        .btnL  (btn[BTN_L]),
        .btnR  (btn[BTN_R]),
        .btnC  (btn[BTN_C]),
        .led   (led),
        .tx    (tx)
    );

    bind cdeBoard cdeBoard_chk cdeBoard_chk_inst (
        .clk   (clk),
        .arstN (arstN),
        .led   (led),
        .tx    (tx)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // UART receiver sampling the middle of each bit
    ////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (!rxActive) begin
            if (arstN && tx == 1'b0) begin
                rxActive = 1'b1;
                rxCnt    = 0;
            end
        end else begin
            rxCnt = rxCnt + 1;
            if (rxCnt % CLKS_PER_BIT == CLKS_PER_BIT / 2) begin
                if (rxCnt < CLKS_PER_BIT) begin
                    assert (tx == 1'b0) else begin
                        rxErrors++;
                        $display("Fail tx start bit: got %h expected %h", tx, 1'b0);
                    end
                end else if (rxCnt < (FRAME_BITS - 1) * CLKS_PER_BIT) begin
                    // LSB first
                    rxShift = {tx, rxShift[7:1]};
                end else begin
                    assert (tx == 1'b1) else begin
                        rxErrors++;
                        $display("Fail tx stop bit: got %h expected %h", tx, 1'b1);
                    end
                    rxBytes.push_back(rxShift);
                    rxActive = 1'b0;
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic stepCycles(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic finishRun();
        $display("Errors: %0d value, %0d receiver, %0d other",
                 valueErrors, rxErrors, otherErrors);
        if (valueErrors == 0 && rxErrors == 0 && otherErrors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    endtask

    task automatic checkValue(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        assert (got === exp) else begin
            valueErrors++;
            $display("Fail %s: got %h expected %h", name, got, exp);
        end
    endtask

    function automatic logic [31:0] nextLfsr(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 32'h80200003;
        end
        return s >> 1;
    endfunction

    task automatic randomBits(input int n, output logic [7:0] value);
        value = 8'h00;
        for (int i = 0; i < n; i++) begin
            lfsrState = nextLfsr(lfsrState);
            value     = {value[6:0], lfsrState[0]};
        end
    endtask

    // Mode table with bits rdA rdB wrA wrB wrU from the LSB up
    function automatic logic [4:0] expectedModeLeds(input logic [1:0] s,
                                                    input logic [1:0] cur);
        logic       side;
        logic [4:0] leds;
        side = (cur >= 2'd2);
        leds = '0;
        case (s)
            2'b00: begin
                leds[4] = 1'b1;
                leds[0] = !side;
                leds[1] = side;
            end
            2'b01: begin
                leds[2] = 1'b1;
                leds[1] = side;
            end
            2'b10: begin
                leds[3] = 1'b1;
                leds[0] = !side;
            end
            default: begin
                leds[2] = !side;
                leds[3] = side;
            end
        endcase
        return leds;
    endfunction

    task automatic applyCenterModel();
        logic       side;
        logic [7:0] word;
        side = (cursorModel >= 2'd2);
        word = {hiModel, loModel};
        case (sw)
            2'b00: begin
                if (!side && queueA.size() > 0) expBytes.push_back(queueA.pop_front());
                if (side && queueB.size() > 0) expBytes.push_back(queueB.pop_front());
            end
            2'b01: begin
                if (!side && queueA.size() < FIFO_DEPTH) queueA.push_back(word);
                if (side && queueB.size() > 0 && queueA.size() < FIFO_DEPTH) begin
                    queueA.push_back(queueB.pop_front());
                end
            end
            2'b10: begin
                if (!side && queueA.size() > 0 && queueB.size() < FIFO_DEPTH) begin
                    queueB.push_back(queueA.pop_front());
                end
                if (side && queueB.size() < FIFO_DEPTH) queueB.push_back(word);
            end
            default: begin
                if (!side && queueA.size() < FIFO_DEPTH) queueA.push_back(word);
                if (side && queueB.size() < FIFO_DEPTH) queueB.push_back(word);
            end
        endcase
    endtask

    // Hold then release for long enough that the debouncer accepts both
    task automatic pressButton(input int index);
        logic loSel;
        loSel = (cursorModel == 2'd0 || cursorModel == 2'd2);
        case (index)
            BTN_L: cursorModel = cursorModel + 2'd1;
            BTN_R: cursorModel = cursorModel - 2'd1;
            BTN_U: begin
                if (loSel) begin
                    loModel = loModel + 4'd1;
                end else begin
                    hiModel = hiModel + 4'd1;
                end
            end
            BTN_D: begin
                if (loSel) begin
                    loModel = loModel - 4'd1;
                end else begin
                    hiModel = hiModel - 4'd1;
                end
            end
            default: applyCenterModel();
        endcase
        btn = BTN_COUNT'(1) << index;
        stepCycles(2 * DEBOUNCE_CYCLES);
        btn = '0;
        stepCycles(2 * DEBOUNCE_CYCLES);
    endtask

    task automatic moveCursorTo(input logic [1:0] target);
        for (int i = 0; i < 4 && cursorModel != target; i++) begin
            pressButton(BTN_L);
        end
    endtask

    task automatic setSwitches(input logic [1:0] value);
        sw = value;
        stepCycles(1);
    endtask

    task automatic checkLeds();
        checkValue("led[4:0]", 8'(led[4:0]), 8'(expectedModeLeds(sw, cursorModel)));
        checkValue("led[6]", 8'(led[6]), 8'(queueA.size() == 0));
        checkValue("led[7]", 8'(led[7]), 8'(queueA.size() == FIFO_DEPTH));
        checkValue("led[8]", 8'(led[8]), 8'(queueB.size() == 0));
        checkValue("led[9]", 8'(led[9]), 8'(queueB.size() == FIFO_DEPTH));
    endtask

    task automatic enterDigits();
        logic [7:0] ups;
        logic [7:0] downs;
        randomBits(3, ups);
        randomBits(2, downs);
        repeat (ups) pressButton(BTN_U);
        repeat (downs) pressButton(BTN_D);
    endtask

    // Wait for every expected byte, then compare in order
    task automatic checkReceived();
        int waited;
        int limit;
        waited = 0;
        limit  = expBytes.size() * 2 * FRAME_BITS * CLKS_PER_BIT;
        while (rxBytes.size() < rxRead + expBytes.size() && waited < limit) begin
            stepCycles(1);
            waited++;
        end
        if (rxBytes.size() < rxRead + expBytes.size()) begin
            otherErrors++;
            $display("Timeout while waiting for a byte on the UART line");
            finishRun();
        end else begin
            while (expBytes.size() > 0) begin
                checkValue("rx byte", rxBytes[rxRead], expBytes.pop_front());
                rxRead++;
            end
        end
    endtask

    task automatic waitForTxIdle();
        int waited;
        waited = 0;
        while (led[5] && waited < 2 * CLKS_PER_BIT) begin
            stepCycles(1);
            waited++;
        end
        if (led[5]) begin
            otherErrors++;
            $display("Timeout while waiting for the transmitter to go idle");
            finishRun();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////

    initial begin
        logic sawLow;
        logic sawBusy;
        arstN       = 1'b0;
        sw          = 2'b00;
        btn         = '0;
        cursorModel = 2'd0;
        hiModel     = 4'd0;
        loModel     = 4'd0;
        lfsrState   = 32'h9b89;
        valueErrors = 0;
        otherErrors = 0;
        rxRead      = 0;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        stepCycles(2);

        // After reset
        checkValue("tx", 8'(tx), 8'h01);
        checkValue("led[5]", 8'(led[5]), 8'h00);
        checkLeds();

        // Mode LEDs at every switch setting and cursor position
        for (int s = 0; s < 4; s++) begin
            setSwitches(2'(s));
            for (int p = 0; p < 4; p++) begin
                checkLeds();
                pressButton(BTN_L);
            end
        end
        pressButton(BTN_R);
        checkLeds();
        pressButton(BTN_R);
        checkLeds();

        // Random digits, push into A, send from A
        moveCursorTo(2'd0);
        enterDigits();
        moveCursorTo(2'd1);
        enterDigits();
        setSwitches(2'b11);
        pressButton(BTN_C);
        checkLeds();
        setSwitches(2'b00);
        pressButton(BTN_C);
        checkReceived();
        checkLeds();

        // Push into A, move to B, send from B
        pressButton(BTN_U);
        setSwitches(2'b11);
        pressButton(BTN_C);
        setSwitches(2'b10);
        pressButton(BTN_C);
        checkLeds();
        moveCursorTo(2'd2);
        setSwitches(2'b00);
        pressButton(BTN_C);
        checkReceived();
        checkLeds();

        // Fill B, one push too many, then drain in order
        setSwitches(2'b11);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pressButton(BTN_U);
            pressButton(BTN_C);
        end
        checkLeds();
        pressButton(BTN_C);
        checkLeds();
        setSwitches(2'b00);
        for (int i = 0; i < FIFO_DEPTH; i++) begin
            pressButton(BTN_C);
            checkReceived();
        end
        checkLeds();

        // Send from an empty FIFO and expect a quiet line
        waitForTxIdle();
        moveCursorTo(2'd0);
        pressButton(BTN_C);
        sawLow  = 1'b0;
        sawBusy = 1'b0;
        for (int i = 0; i < 2 * FRAME_BITS * CLKS_PER_BIT; i++) begin
            stepCycles(1);
            if (tx == 1'b0) sawLow = 1'b1;
            if (led[5]) sawBusy = 1'b1;
        end
        checkValue("tx low seen", 8'(sawLow), 8'h00);
        checkValue("led[5] high seen", 8'(sawBusy), 8'h00);
        checkValue("rx byte count", 8'(rxBytes.size() - rxRead), 8'h00);
        checkLeds();

        finishRun();
    end

endmodule

`default_nettype wire

// ==== cdeBoard.f ====
verilog/cdePkg.sv
verilog/cdeFifoIf.sv
verilog/buttonDebounce.sv
verilog/panelControl.sv
verilog/syncFifo.sv
verilog/transferSequencer.sv
verilog/uartTx.sv
verilog/cdeBoard.sv
verif/cdeBoard_chk.sv
verif/cdeBoardTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 --top-module cdeBoardTb \
        -f cdeBoard.f --Mdir obj_dir -o cdeBoardSim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/cdeBoardSim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi

cat "$LOG"

if grep -q "TEST RESULT: PASS" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
